//--- hw/note_synth_pkg.sv
package note_synth_pkg;

    // ------------------------------
    // Widths
    // ------------------------------

    localparam int note_w   = 4;   // Key code and note code
    localparam int octave_w = 3;   // Octave switches
    localparam int sample_w = 16;  // Signed audio sample
    localparam int seg_w    = 8;   // Order a b c d e f g h

    // Twelve note names of one octave, C first
    typedef enum logic [note_w - 1:0] {
        note_c  = 4'd0,
        note_cs = 4'd1,
        note_d  = 4'd2,
        note_ds = 4'd3,
        note_e  = 4'd4,
        note_f  = 4'd5,
        note_fs = 4'd6,
        note_g  = 4'd7,
        note_gs = 4'd8,
        note_a  = 4'd9,
        note_as = 4'd10,
        note_b  = 4'd11
    } note_t;

    // ------------------------------
    // Tone data
    // ------------------------------

    // C4 to B4 in millihertz, equal temperament around A4 = 440 Hz
    localparam logic [31:0] note_mhz_table [12] = '{
        32'd261626,  // C4
        32'd277183,
        32'd293665,
        32'd311127,
        32'd329628,
        32'd349228,  // F4
        32'd369994,
        32'd391995,
        32'd415305,
        32'd440000,  // A4
        32'd466164,
        32'd493883
    };

    localparam logic [sample_w - 1:0] tone_amplitude = 16'h3000;  // Well below full scale

    // Letter shapes, h segment set on sharps
    localparam logic [seg_w - 1:0] seg_table [12] = '{
        8'b1001_1100,  // C
        8'b1001_1101,  // C#
        8'b0111_1010,  // d
        8'b0111_1011,  // d#
        8'b1001_1110,  // E
        8'b1000_1110,  // F
        8'b1000_1111,  // F#
        8'b1011_1100,  // G
        8'b1011_1101,  // G#
        8'b1110_1110,  // A
        8'b1110_1111,  // A#
        8'b0011_1110   // b
    };

endpackage

//--- hw/note_if.sv
`timescale 1ns/100ps

// Current note as seen by the whole design
interface note_if;

    note_synth_pkg::note_t                note;         // Valid only with note_on
    logic [note_synth_pkg::octave_w - 1:0] octave;
    logic                                 note_on;      // Level, key held
    logic                                 note_change;  // One-cycle pulse

    modport src (
        output note,
        output octave,
        output note_on,
        output note_change
    );

    modport dst (
        input  note,
        input  octave,
        input  note_on,
        input  note_change
    );

endinterface

//--- hw/key_scan.sv
`timescale 1ns/100ps

module key_scan #(
    parameter int debounce_cycles = 8
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [note_synth_pkg::note_w   - 1:0] key,
    input  logic [note_synth_pkg::octave_w - 1:0] sw,
    note_if.src                                   note_out
);

    localparam int in_w  = note_synth_pkg::note_w + note_synth_pkg::octave_w;
    localparam int cnt_w = $clog2(debounce_cycles + 1);

    localparam logic [cnt_w - 1:0] cnt_last = cnt_w'(debounce_cycles - 1);  // Accept here
    localparam logic [cnt_w - 1:0] cnt_full = cnt_w'(debounce_cycles);      // Saturated

    logic [in_w - 1:0]                     sync_1;    // Metastability stage
    logic [in_w - 1:0]                     sync_2;
    logic [in_w - 1:0]                     cand;      // Value being timed
    logic [cnt_w - 1:0]                    cnt;
    logic                                  accept;
    logic [note_synth_pkg::note_w   - 1:0] cand_key;
    logic [note_synth_pkg::octave_w - 1:0] cand_sw;
    logic                                  dec_on;
    note_synth_pkg::note_t                 dec_note;
    logic                                  differs;

    // ------------------------------
    // Synchronizer and debounce
    // ------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= {sw, key};
            sync_2 <= sync_1;
        end
    end

    // Any change restarts the stability count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cand <= '0;
            cnt  <= '0;
        end else if (sync_2 != cand) begin
            cand <= sync_2;
            cnt  <= '0;
        end else if (cnt != cnt_full) begin
            cnt  <= cnt + 1'b1;  // Stops at full, so one accept per value
        end
    end

    assign accept = (sync_2 == cand) && (cnt == cnt_last);

    // ------------------------------
    // Decode
    // ------------------------------

    assign {cand_sw, cand_key} = cand;
    assign dec_on   = cand_key < note_synth_pkg::note_w'(12);  // 12..15 are rests
    assign dec_note = dec_on ? note_synth_pkg::note_t'(cand_key) : note_synth_pkg::note_c;

    // Glitch that settles back to the old value gives no pulse
    assign differs = (dec_note != note_out.note)
                  || (cand_sw != note_out.octave)
                  || (dec_on  != note_out.note_on);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            note_out.note        <= note_synth_pkg::note_c;
            note_out.octave      <= '0;
            note_out.note_on     <= 1'b0;
            note_out.note_change <= 1'b0;
        end else begin
            note_out.note_change <= accept && differs;
            if (accept) begin
                note_out.note    <= dec_note;
                note_out.octave  <= cand_sw;
                note_out.note_on <= dec_on;
            end
        end
    end

endmodule

//--- hw/tone_sel.sv
`timescale 1ns/100ps

module tone_sel #(
    parameter int clk_mhz = 50
) (
    input  logic                                         clk,
    input  logic                                         rst,
    note_if.dst                                          note_in,
    output logic signed [note_synth_pkg::sample_w - 1:0] sound
);

    localparam int period_w = 32;  // Room for slow tones at fast clocks

    localparam logic signed [note_synth_pkg::sample_w - 1:0] amp =
        $signed(note_synth_pkg::tone_amplitude);

    logic [period_w - 1:0] base_period [12];  // Octave 0 half periods
    logic [period_w - 1:0] half_period;       // Selected and shifted
    logic [period_w - 1:0] cnt;               // Cycles left before the flip

    // ------------------------------
    // Divisor table
    // ------------------------------

    // Clock in millihertz over twice the note frequency, rounded down
    for (genvar i = 0; i < 12; i++) begin : g_period
        localparam longint unsigned clk_mhz_units = longint'(clk_mhz) * 64'd1_000_000_000;
        localparam longint unsigned note_units    = 64'(note_synth_pkg::note_mhz_table[i]);
        localparam longint unsigned period        = clk_mhz_units / (64'd2 * note_units);

        assign base_period[i] = period_w'(period);
    end

    // Each octave up halves the period
    assign half_period = base_period[note_in.note] >> note_in.octave;

    // ------------------------------
    // Square wave
    // ------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sound <= '0;
            cnt   <= '0;
        end else if (!note_in.note_on) begin
            // Rest, silence and hold the counter
            sound <= '0;
            cnt   <= '0;
        end else if (note_in.note_change) begin
            sound <= amp;                  // Restart on the high half
            cnt   <= half_period - 1'b1;
        end else if (cnt == '0) begin
            sound <= -sound;               // Sign flip
            cnt   <= half_period - 1'b1;   // Octave change also lands here
        end else begin
            cnt   <= cnt - 1'b1;
        end
    end

endmodule

//--- hw/note_display.sv
`timescale 1ns/100ps

module note_display #(
    parameter int w_digit = 8
) (
    input  logic                                clk,
    input  logic                                rst,
    note_if.dst                                 note_in,
    output logic [note_synth_pkg::seg_w  - 1:0] segments,
    output logic [w_digit - 1:0]                digit,
    output logic [note_synth_pkg::note_w - 1:0] led
);

    logic [note_synth_pkg::seg_w - 1:0] pattern;  // Lookup for the current note

    // ------------------------------
    // Pattern lookup
    // ------------------------------

    // Layout of one digit
    //
    //    --a--
    //   f     b
    //    --g--
    //   e     c
    //    --d--  h
    assign pattern = note_synth_pkg::seg_table[note_in.note];

    // ------------------------------
    // Output registers
    // ------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            segments <= '0;
            led      <= '0;
        end else if (note_in.note_on) begin
            segments <= pattern;
            led      <= note_synth_pkg::note_w'(note_in.note);  // Same as key code
        end else begin
            // Blank on rest
            segments <= '0;
            led      <= '0;
        end
    end

    // Only the rightmost digit is lit, no scanning
    assign digit = w_digit'(1);

endmodule

//--- hw/note_synth_top.sv
`timescale 1ns/100ps

module note_synth_top #(
    parameter int clk_mhz         = 50,
    parameter int debounce_cycles = 250_000,  // About 5 ms at 50 MHz
    parameter int w_digit         = 8
) (
    input  logic                                         clk,
    input  logic                                         rst,

    // Keys give the note, switches the octave
    input  logic        [note_synth_pkg::note_w   - 1:0] key,
    input  logic        [note_synth_pkg::octave_w - 1:0] sw,

    // Display and LEDs
    output logic        [note_synth_pkg::seg_w    - 1:0] segments,
    output logic        [w_digit - 1:0]                  digit,
    output logic        [note_synth_pkg::note_w   - 1:0] led,

    // Audio
    output logic signed [note_synth_pkg::sample_w - 1:0] sound
);

    note_if note_bus ();  // Shared current-note bundle

    // ------------------------------
    // Input side
    // ------------------------------

    key_scan #(
        .debounce_cycles (debounce_cycles)
    ) u_key_scan (
        .clk      (clk),
        .rst      (rst),
        .key      (key),
        .sw       (sw),
        .note_out (note_bus.src)
    );

    // ------------------------------
    // Tone and display
    // ------------------------------

    tone_sel #(
        .clk_mhz (clk_mhz)
    ) u_tone_sel (
        .clk     (clk),
        .rst     (rst),
        .note_in (note_bus.dst),
        .sound   (sound)
    );

    note_display #(
        .w_digit (w_digit)
    ) u_note_display (
        .clk      (clk),
        .rst      (rst),
        .note_in  (note_bus.dst),
        .segments (segments),
        .digit    (digit),
        .led      (led)
    );

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/100ps

// Free running testbench clock
module tb_clk_gen #(
    parameter int period_ns = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;  // 50 percent duty
    end

endmodule

//--- dv/note_synth_tb.sv
`timescale 1ns/100ps

module note_synth_tb;

    localparam int clk_mhz         = 1;   // Slow clock keeps tones short
    localparam int debounce_cycles = 8;
    localparam int w_digit         = 8;
    localparam int reset_cycles    = 16;
    localparam int settle_cycles   = 3 + debounce_cycles + 2 + 4;  // Sync, debounce, regs, margin
    localparam int rest_window     = 64;  // Cycles of silence checked per rest

    logic                                         clk;
    logic                                         rst;
    logic        [note_synth_pkg::note_w   - 1:0] key;
    logic        [note_synth_pkg::octave_w - 1:0] sw;
    logic        [note_synth_pkg::seg_w    - 1:0] segments;
    logic        [w_digit - 1:0]                  digit;
    logic        [note_synth_pkg::note_w   - 1:0] led;
    logic signed [note_synth_pkg::sample_w - 1:0] sound;

    // One entry per stimulus line
    int key_q[$];
    int sw_q[$];
    int seg_q[$];
    int period_q[$];

    int watchdog_cycles;  // Zero until the stimulus is read

    tb_clk_gen #(
        .period_ns (10)
    ) u_clk_gen (
        .clk (clk)
    );

    note_synth_top #(
        .clk_mhz         (clk_mhz),
        .debounce_cycles (debounce_cycles),
        .w_digit         (w_digit)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .key      (key),
        .sw       (sw),
        .segments (segments),
        .digit    (digit),
        .led      (led),
        .sound    (sound)
    );

    // ------------------------------
    // Checks
    // ------------------------------

    task automatic check_equal(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("FAIL %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic stop_with_error(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "Run aborted");
    endtask

    // LEDs mirror the key code, dark on rests
    function automatic int expected_led(input int code);
        return (code < 12) ? code : 0;
    endfunction

    task automatic check_display(input int exp_seg, input int exp_led);
        check_equal(int'(segments), exp_seg, "segments");
        check_equal(int'(led), exp_led, "led");
        check_equal(int'(digit), 1, "digit");  // Lowest digit only
    endtask

    task automatic check_magnitude();
        int mag;
        mag = (sound < 0) ? -int'(sound) : int'(sound);
        check_equal(mag, int'(note_synth_pkg::tone_amplitude), "sound magnitude");
    endtask

    task automatic check_silence(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_equal(int'(sound), 0, "sound during rest");
        end
    endtask

    // Cycles between two sign flips, phase at entry unknown
    task automatic measure_half_period(input int limit, output int cycles);
        logic signed [note_synth_pkg::sample_w - 1:0] level;
        int                                           n;
        n     = 0;
        level = sound;
        while (sound == level && n <= limit) begin
            @(negedge clk);
            n++;
        end
        check_magnitude();
        level = sound;
        n     = 0;
        while (sound == level && n <= limit) begin  // Full half period
            @(negedge clk);
            n++;
        end
        check_magnitude();
        cycles = n;
    endtask

    // Display held and flips kept on the running tone grid, every cycle
    task automatic watch_steady(input int cycles, input int exp_seg, input int exp_led,
                                input int half_period, inout int since_flip);
        logic signed [note_synth_pkg::sample_w - 1:0] prev;
        prev = sound;
        repeat (cycles) begin
            @(negedge clk);
            since_flip++;
            check_display(exp_seg, exp_led);
            check_magnitude();
            if (sound != prev) begin
                check_equal(since_flip, half_period, "flip spacing across glitch");
                since_flip = 0;
            end
            prev = sound;
        end
    endtask

    // ------------------------------
    // Stimulus file
    // ------------------------------

    task automatic read_stimulus();
        int    fd;
        int    k;
        int    s;
        int    seg;
        int    hp;
        string line;
        fd = $fopen("dv/note_stimulus.txt", "r");
        if (fd == 0) begin
            stop_with_error("Cannot open the stimulus file dv/note_stimulus.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                // Comment lines do not parse
                if ($sscanf(line, "%h %h %h %d", k, s, seg, hp) == 4) begin
                    key_q.push_back(k);
                    sw_q.push_back(s);
                    seg_q.push_back(seg);
                    period_q.push_back(hp);
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        int                                  idx;
        int                                  measured;
        int                                  max_period;
        int                                  glitch_len;
        int                                  since_flip;
        logic [note_synth_pkg::note_w - 1:0] glitch_key;

        rst             = 1'b1;
        key             = 4'hf;  // Rest code, nothing plays after reset
        sw              = '0;
        watchdog_cycles = 0;
        void'($urandom(44));

        read_stimulus();
        if (key_q.size() == 0) begin
            stop_with_error("The stimulus file holds no test lines");
        end

        max_period = 0;
        foreach (period_q[i]) begin
            if (period_q[i] > max_period) max_period = period_q[i];
        end
        watchdog_cycles = (4 * 2 * max_period + 2 * settle_cycles + 6) * key_q.size() * 2
                        + reset_cycles + 2 * settle_cycles;

        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;

        // Outputs quiet out of reset and after the first debounce
        check_display(0, 0);
        check_equal(int'(sound), 0, "sound after reset");
        repeat (settle_cycles) @(negedge clk);
        check_display(0, 0);
        check_equal(int'(sound), 0, "sound after reset");

        for (idx = 0; idx < key_q.size(); idx++) begin
            key = note_synth_pkg::note_w'(key_q[idx]);    // Already on a falling edge
            sw  = note_synth_pkg::octave_w'(sw_q[idx]);
            repeat (settle_cycles) @(negedge clk);
            check_display(seg_q[idx], expected_led(key_q[idx]));

            if (period_q[idx] == 0) begin
                check_silence(rest_window);
            end else begin
                measure_half_period(2 * max_period, measured);
                check_equal(measured, period_q[idx], "half period");

                // Short glitch on the keys, 1 to 6 cycles, starting right on a flip
                glitch_len = 1 + int'($urandom % 6);
                glitch_key = key ^ note_synth_pkg::note_w'(1 + ($urandom % 15));
                since_flip = 0;
                key        = glitch_key;
                watch_steady(glitch_len, seg_q[idx], expected_led(key_q[idx]),
                             period_q[idx], since_flip);
                key        = note_synth_pkg::note_w'(key_q[idx]);
                watch_steady(settle_cycles + period_q[idx] + 1, seg_q[idx],
                             expected_led(key_q[idx]), period_q[idx], since_flip);

                measure_half_period(2 * max_period, measured);
                check_equal(measured, period_q[idx], "half period after glitch");
            end
        end

        $display("TESTS PASSED");
        $finish;
    end

    // ------------------------------
    // Watchdog
    // ------------------------------

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout, the test did not finish within %0d cycles", watchdog_cycles);
        $display("TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- dv/note_stimulus.txt
# key(hex) sw(hex) segments(hex, order a..h) half_period(decimal cycles at 1 MHz)
# half_period 0 marks a rest, segments and led blank, sound 0
0 0 9c 1911
1 0 9d 1803
2 0 7a 1702
3 0 7b 1607
4 0 9e 1516
5 0 8e 1431
6 0 8f 1351
7 0 bc 1275
8 0 bd 1203
9 0 ee 1136
a 0 ef 1072
b 0 3e 1012
# Octave shift, base period shifted right by the octave
0 1 9c 955
0 3 9c 238
9 1 ee 568
9 3 ee 142
# Rest codes
c 0 00 0
d 0 00 0
e 0 00 0
f 0 00 0
# Note again after rests
8 2 bd 300

//--- tb.f
hw/note_synth_pkg.sv
hw/note_if.sv
hw/key_scan.sv
hw/tone_sel.sv
hw/note_display.sv
hw/note_synth_top.sv
dv/tb_clk_gen.sv
dv/note_synth_tb.sv

//--- Makefile
# Verilator build for the note synthesizer testbench

VERILATOR ?= verilator
TOP       ?= note_synth_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TESTS PASSED

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output is kept in a shell variable and searched for the pass message
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)" || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR)
